// ==== filelist.f ====
+incdir+hdl
hdl/flow_pkg.sv
hdl/flow_if.sv
hdl/dat_table.sv
hdl/cmd_fetch.sv
hdl/imm_byte_seq.sv
hdl/resp_writer.sv
hdl/flow_active.sv
sim/flow_properties.sv
sim/tb_flow_active.sv

// ==== hdl/cmd_fetch.sv ====
// ##################################################
// Command fetch, DAT lookup and dispatch FSM
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module cmd_fetch (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       en_i,
  // HCI command queue
  input  logic                       cmd_rvalid_i,
  input  logic [`FLOW_CMD_W-1:0]     cmd_rdata_i,
  output logic                       cmd_rready_o,
  // DAT lookup
  output logic                       dat_rd_en_o,
  output logic [`FLOW_DAT_IDX_W-1:0] dat_rd_idx_o,
  input  flow_pkg::dat_entry_t       dat_rd_data_i,
  // Sequencer and response writer
  job_if.fetch                       job,
  resp_if.fetch                      resp,
  output logic                       idle_o
);
  import flow_pkg::*;

  typedef enum logic [2:0] {
    Idle, WaitCmd, DatRead, DatWait, RunSeq, RespWait
  } fetch_state_e;

  fetch_state_e  state_q, state_d;
  imm_cmd_desc_t desc_q;
  logic [6:0]    addr_q;
  logic          cmd_pop;
  logic          supported;

  assign cmd_pop = cmd_rvalid_i & cmd_rready_o;

  // Only immediate writes to legacy I2C targets are executed
  assign supported = (desc_q.attr == ImmediateDataTransfer) & ~desc_q.rnw &
                     dat_rd_data_i.device;

  // Descriptor and address payload
  always_ff @(posedge clk_i) begin
    if (cmd_pop) begin
      desc_q <= cmd_rdata_i;
    end
    if (state_q == DatWait) begin
      addr_q <= dat_rd_data_i.static_addr;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:     if (en_i) state_d = WaitCmd;
      WaitCmd: begin
        if (!en_i) begin
          state_d = Idle;
        end else if (cmd_rvalid_i) begin
          state_d = DatRead;
        end
      end
      DatRead:  state_d = DatWait;
      // Entry is valid here, dispatch or reject
      DatWait:  state_d = supported ? RunSeq : RespWait;
      RunSeq:   if (job.done) state_d = RespWait;
      RespWait: if (!resp.busy) state_d = Idle;
      default:  state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Queue pop only while enabled
  assign cmd_rready_o = (state_q == WaitCmd) & en_i;
  assign dat_rd_en_o  = (state_q == DatRead);
  assign dat_rd_idx_o = desc_q.dev_idx;

  assign job.start       = (state_q == DatWait) & supported;
  assign job.desc        = desc_q;
  assign job.static_addr = addr_q;

  // Reject right away, or report success when the sequencer finishes
  assign resp.post     = ((state_q == DatWait) & ~supported) | ((state_q == RunSeq) & job.done);
  assign resp.status   = (state_q == RunSeq) ? Success : Unsupported;
  assign resp.tid      = desc_q.tid;
  assign resp.data_len = '0;

  // Idle again as soon as the response has left
  assign idle_o = (state_q == Idle) | ((state_q == RespWait) & ~resp.busy);

endmodule

// ==== hdl/dat_table.sv ====
// ##################################################
// Device address table, software write, HW read
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module dat_table (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Software programming port
  input  logic                       wr_en_i,
  input  logic [`FLOW_DAT_IDX_W-1:0] wr_idx_i,
  input  flow_pkg::dat_entry_t       wr_data_i,
  // Controller lookup port
  input  logic                       rd_en_i,
  input  logic [`FLOW_DAT_IDX_W-1:0] rd_idx_i,
  output flow_pkg::dat_entry_t       rd_data_o
);
  import flow_pkg::*;

  dat_entry_t entries_q [`FLOW_DAT_DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // All targets unknown after reset
      for (int i = 0; i < `FLOW_DAT_DEPTH; i++) begin
        entries_q[i] <= '0;
      end
      rd_data_o <= '0;
    end else begin
      if (wr_en_i) begin
        entries_q[wr_idx_i] <= wr_data_i;
      end
      // Read data held until the next strobe
      if (rd_en_i) begin
        rd_data_o <= entries_q[rd_idx_i];
      end
    end
  end

endmodule

// ==== hdl/flow_active.sv ====
// ##################################################
// I3C command flow top, immediate I2C writes only
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module flow_active (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       i3c_fsm_en_i,
  // HCI command queue
  input  logic                       cmd_queue_rvalid_i,
  input  logic [`FLOW_CMD_W-1:0]     cmd_queue_rdata_i,
  output logic                       cmd_queue_rready_o,
  // I2C controller format FIFO
  output logic                       fmt_fifo_rvalid_o,
  input  logic                       fmt_fifo_rready_i,
  output logic [7:0]                 fmt_byte_o,
  output logic                       fmt_flag_start_before_o,
  output logic                       fmt_flag_stop_after_o,
  // HCI response queue
  output logic                       resp_queue_wvalid_o,
  input  logic                       resp_queue_wready_i,
  output logic [`FLOW_RESP_W-1:0]    resp_queue_wdata_o,
  // DAT programming
  input  logic                       dat_wr_en_i,
  input  logic [`FLOW_DAT_IDX_W-1:0] dat_wr_idx_i,
  input  flow_pkg::dat_entry_t       dat_wr_data_i,
  output logic                       i3c_fsm_idle_o
);
  import flow_pkg::*;

  logic                       dat_rd_en;
  logic [`FLOW_DAT_IDX_W-1:0] dat_rd_idx;
  dat_entry_t                 dat_rd_data;

  job_if  u_job_if ();
  resp_if u_resp_if ();

  dat_table u_dat (
    .clk_i, .rst_ni,
    .wr_en_i   (dat_wr_en_i),
    .wr_idx_i  (dat_wr_idx_i),
    .wr_data_i (dat_wr_data_i),
    .rd_en_i   (dat_rd_en),
    .rd_idx_i  (dat_rd_idx),
    .rd_data_o (dat_rd_data)
  );

  cmd_fetch u_fetch (
    .clk_i, .rst_ni,
    .en_i          (i3c_fsm_en_i),
    .cmd_rvalid_i  (cmd_queue_rvalid_i),
    .cmd_rdata_i   (cmd_queue_rdata_i),
    .cmd_rready_o  (cmd_queue_rready_o),
    .dat_rd_en_o   (dat_rd_en),
    .dat_rd_idx_o  (dat_rd_idx),
    .dat_rd_data_i (dat_rd_data),
    .job           (u_job_if.fetch),
    .resp          (u_resp_if.fetch),
    .idle_o        (i3c_fsm_idle_o)
  );

  imm_byte_seq u_seq (
    .clk_i, .rst_ni,
    .job          (u_job_if.seq),
    .fmt_rvalid_o (fmt_fifo_rvalid_o),
    .fmt_rready_i (fmt_fifo_rready_i),
    .fmt_byte_o   (fmt_byte_o),
    .fmt_start_o  (fmt_flag_start_before_o),
    .fmt_stop_o   (fmt_flag_stop_after_o)
  );

  resp_writer u_resp (
    .clk_i, .rst_ni,
    .resp     (u_resp_if.writer),
    .wvalid_o (resp_queue_wvalid_o),
    .wready_i (resp_queue_wready_i),
    .wdata_o  (resp_queue_wdata_o)
  );

endmodule

// ==== hdl/flow_if.sv ====
// ##################################################
// Internal job and response hand-off interfaces
// ##################################################
`timescale 1ns/1ps

// Fetch unit to byte sequencer, start/done pulses
interface job_if;
  import flow_pkg::*;

  logic          start;
  imm_cmd_desc_t desc;
  logic [6:0]    static_addr;
  logic          done;

  // desc and static_addr held from start until done
  modport fetch (output start, output desc, output static_addr, input done);
  modport seq (input start, input desc, input static_addr, output done);
endinterface

// Fetch unit to response writer
interface resp_if;
  import flow_pkg::*;

  logic        post;
  logic [3:0]  tid;
  resp_err_e   status;
  logic [15:0] data_len;
  // High while a response waits for the queue
  logic        busy;

  modport fetch (output post, output tid, output status, output data_len, input busy);
  modport writer (input post, input tid, input status, input data_len, output busy);
endinterface

// ==== hdl/flow_macros.svh ====
// ##################################################
// Sizing constants for the I3C command-flow block
// ##################################################
`ifndef FLOW_MACROS_SVH
`define FLOW_MACROS_SVH

// HCI command descriptor width
`define FLOW_CMD_W 64

// HCI response descriptor width
`define FLOW_RESP_W 32

// Device address table size
`define FLOW_DAT_DEPTH 32
`define FLOW_DAT_IDX_W 5

// Target address byte ahead of immediate data
`define FLOW_BYTES_BEFORE_IMM 1

`endif

// ==== hdl/flow_pkg.sv ====
// ##################################################
// Descriptor, table and status types of the flow
// ##################################################
`include "flow_macros.svh"

package flow_pkg;

  // Command attribute, low 3 bits of every descriptor
  typedef enum logic [2:0] {
    RegularTransfer       = 3'd0,
    ImmediateDataTransfer = 3'd1,
    AddressAssignment     = 3'd2,
    ComboTransfer         = 3'd3,
    InternalControl       = 3'd7
  } cmd_attr_e;

  // Immediate data transfer descriptor, MSB first
  typedef struct packed {
    logic [7:0]                 byte4;
    logic [7:0]                 byte3;
    logic [7:0]                 byte2;
    logic [7:0]                 def_or_byte1;
    logic                       toc;
    logic                       roc;
    logic                       rnw;
    logic [2:0]                 mode;
    // 0-4 plain bytes, 5-7 defining byte plus dtt-5
    logic [2:0]                 dtt;
    logic [1:0]                 rsvd;
    logic [`FLOW_DAT_IDX_W-1:0] dev_idx;
    logic                       cp;
    logic [7:0]                 ccc;
    logic [3:0]                 tid;
    cmd_attr_e                  attr;
  } imm_cmd_desc_t;

  // One DAT entry, device set marks a legacy I2C target
  typedef struct packed {
    logic       device;
    logic       rsvd;
    logic [6:0] static_addr;
  } dat_entry_t;

  // Response status codes
  typedef enum logic [3:0] {
    Success     = 4'h0,
    Unsupported = 4'hC
  } resp_err_e;

  // Response descriptor, MSB first
  typedef struct packed {
    resp_err_e   status;
    logic [3:0]  tid;
    logic [7:0]  rsvd;
    logic [15:0] data_len;
  } resp_desc_t;

endpackage

// ==== hdl/imm_byte_seq.sv ====
// ##################################################
// Immediate write byte sequencer to I2C format FIFO
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module imm_byte_seq (
  input  logic       clk_i,
  input  logic       rst_ni,
  job_if.seq         job,
  // I2C controller format FIFO
  output logic       fmt_rvalid_o,
  input  logic       fmt_rready_i,
  output logic [7:0] fmt_byte_o,
  output logic       fmt_start_o,
  output logic       fmt_stop_o
);

  logic       active_q;
  logic       done_q;
  logic [2:0] cnt_q;
  logic       use_def;
  logic [2:0] n_data;
  logic [2:0] last_idx;
  logic [2:0] data_idx;
  logic       accept;
  logic       is_last;

  // dtt 5-7 carries a defining byte that is skipped
  assign use_def  = (job.desc.dtt > 3'd4);
  assign n_data   = use_def ? job.desc.dtt - 3'd5 : job.desc.dtt;
  assign last_idx = n_data + 3'(`FLOW_BYTES_BEFORE_IMM) - 3'd1;
  assign is_last  = (cnt_q == last_idx);
  assign accept   = active_q & fmt_rready_i;

  // Data byte slot behind the address byte
  assign data_idx = cnt_q - 3'(`FLOW_BYTES_BEFORE_IMM) + {2'b00, use_def};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (job.start) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (accept) begin
        if (is_last) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 3'd1;
        end
      end
    end
  end

  always_comb begin
    if (cnt_q == 3'd0) begin
      // Write address, R/W bit clear
      fmt_byte_o = {job.static_addr, 1'b0};
    end else begin
      unique case (data_idx)
        3'd0:    fmt_byte_o = job.desc.def_or_byte1;
        3'd1:    fmt_byte_o = job.desc.byte2;
        3'd2:    fmt_byte_o = job.desc.byte3;
        3'd3:    fmt_byte_o = job.desc.byte4;
        default: fmt_byte_o = '0;
      endcase
    end
  end

  // Valid stays up under back-pressure
  assign fmt_rvalid_o = active_q;
  assign fmt_start_o  = (cnt_q == 3'd0);
  assign fmt_stop_o   = is_last & job.desc.toc;
  assign job.done     = done_q;

endmodule

// ==== hdl/resp_writer.sv ====
// ##################################################
// Response descriptor builder and queue writer
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module resp_writer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  resp_if.writer                 resp,
  // HCI response queue
  output logic                   wvalid_o,
  input  logic                   wready_i,
  output logic [`FLOW_RESP_W-1:0] wdata_o
);
  import flow_pkg::*;

  resp_desc_t desc_q;
  logic       pending_q;

  // Descriptor captured at post, held until accepted
  always_ff @(posedge clk_i) begin
    if (resp.post) begin
      desc_q.status   <= resp.status;
      desc_q.tid      <= resp.tid;
      desc_q.rsvd     <= '0;
      desc_q.data_len <= resp.data_len;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (resp.post) begin
      pending_q <= 1'b1;
    end else if (wready_i) begin
      // Handshake completes the write
      pending_q <= 1'b0;
    end
  end

  assign wvalid_o  = pending_q;
  assign wdata_o   = desc_q;
  assign resp.busy = pending_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the flow_active testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_flow_active -Mdir obj_dir -o sim_flow > build.log 2>&1 \
  && ./obj_dir/sim_flow > sim.log 2>&1 \
  || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "^STATUS: PASS$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/flow_properties.sv ====
// ##################################################
// Handshake checks bound to the command-flow top
// ##################################################
`timescale 1ns/1ps

module flow_properties (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        fmt_fifo_rvalid_o,
  input logic        fmt_fifo_rready_i,
  input logic [7:0]  fmt_byte_o,
  input logic        fmt_flag_start_before_o,
  input logic        fmt_flag_stop_after_o,
  input logic        resp_queue_wvalid_o,
  input logic        resp_queue_wready_i,
  input logic [31:0] resp_queue_wdata_o,
  input logic        cmd_queue_rready_o,
  input logic        i3c_fsm_idle_o
);

  // Format byte held while the FIFO stalls
  fmt_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fmt_fifo_rvalid_o && !fmt_fifo_rready_i |=> fmt_fifo_rvalid_o &&
    $stable({fmt_byte_o, fmt_flag_start_before_o, fmt_flag_stop_after_o}))
    else $error("format FIFO byte changed while stalled");

  // Response word held until accepted
  resp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_queue_wvalid_o && !resp_queue_wready_i |=> resp_queue_wvalid_o &&
    $stable(resp_queue_wdata_o))
    else $error("response word changed while stalled");

  fmt_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(fmt_fifo_rvalid_o && i3c_fsm_idle_o))
    else $error("format valid while the FSM reports idle");

  // Quiet outputs in reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !rst_ni |-> !fmt_fifo_rvalid_o && !resp_queue_wvalid_o && !cmd_queue_rready_o)
    else $error("valid output raised during reset");

endmodule

bind flow_active flow_properties u_props (.*);

// ==== sim/tb_flow_active.sv ====
// ##################################################
// Directed tests for the I3C command-flow top
// ##################################################
`timescale 1ns/1ps
`include "flow_macros.svh"

module tb_flow_active;
  import flow_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic        i3c_fsm_en_i;
  logic        cmd_queue_rvalid_i;
  logic [63:0] cmd_queue_rdata_i;
  logic        cmd_queue_rready_o;
  logic        fmt_fifo_rvalid_o;
  logic        fmt_fifo_rready_i;
  logic [7:0]  fmt_byte_o;
  logic        fmt_flag_start_before_o;
  logic        fmt_flag_stop_after_o;
  logic        resp_queue_wvalid_o;
  logic        resp_queue_wready_i;
  logic [31:0] resp_queue_wdata_o;
  logic        dat_wr_en_i;
  logic [4:0]  dat_wr_idx_i;
  dat_entry_t  dat_wr_data_i;
  logic        i3c_fsm_idle_o;

  // Command queue model
  logic [63:0] cmd_mem [16];
  int          cmd_ptr;
  int          cmd_count;
  int          pop_count;
  int          resp_count;
  bit          rand_ready;

  // Captured traffic as {start, stop, byte}, and expected values
  logic [9:0]  fmt_q[$];
  logic [9:0]  exp_fmt[$];
  logic [31:0] resp_q[$];
  logic [31:0] exp_resp[$];

  int errors;
  int tests_run;
  int tests_failed;

  flow_active DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Inputs change on the falling edge only
  always @(negedge clk_i) begin
    cmd_queue_rvalid_i = (cmd_ptr < cmd_count);
    cmd_queue_rdata_i  = cmd_mem[cmd_ptr[3:0]];
    fmt_fifo_rready_i  = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    resp_queue_wready_i = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  // Transfers seen at the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (cmd_queue_rvalid_i && cmd_queue_rready_o) begin
        assert (pop_count == resp_count) else begin
          $display("Error at %0t: command popped before previous response", $time);
          errors++;
        end
        assert (i3c_fsm_en_i) else begin
          $display("Error at %0t: command popped while disabled", $time);
          errors++;
        end
        cmd_ptr++;
        pop_count++;
      end
      if (fmt_fifo_rvalid_o && fmt_fifo_rready_i) begin
        fmt_q.push_back({fmt_flag_start_before_o, fmt_flag_stop_after_o, fmt_byte_o});
      end
      if (resp_queue_wvalid_o && resp_queue_wready_i) begin
        resp_q.push_back(resp_queue_wdata_o);
        resp_count++;
      end
    end
  end

  // Descriptor bits laid out low to high
  function automatic logic [63:0] make_cmd(input logic [2:0] attr, input logic [3:0] tid,
                                           input logic [4:0] idx, input logic [2:0] dtt,
                                           input logic rnw, input logic toc,
                                           input logic [31:0] data);
    logic [63:0] w;
    w        = '0;
    w[2:0]   = attr;
    w[6:3]   = tid;
    w[20:16] = idx;
    w[25:23] = dtt;
    w[29]    = rnw;
    w[31]    = toc;
    w[63:32] = data;
    return w;
  endfunction

  // Expected bytes of a supported immediate write
  function automatic void expect_write(input logic [63:0] w, input logic [6:0] addr);
    logic [2:0] dtt;
    int         n;
    int         first;
    dtt   = w[25:23];
    n     = (dtt > 4) ? dtt - 5 : dtt;
    first = (dtt > 4) ? 1 : 0;
    exp_fmt.push_back({1'b1, (n == 0) ? w[31] : 1'b0, addr, 1'b0});
    for (int i = 0; i < n; i++) begin
      exp_fmt.push_back({1'b0, (i == n - 1) ? w[31] : 1'b0, w[32 + 8 * (first + i) +: 8]});
    end
    exp_resp.push_back({4'h0, w[6:3], 24'h0});
  endfunction

  function automatic void expect_reject(input logic [63:0] w);
    exp_resp.push_back({4'hC, w[6:3], 24'h0});
  endfunction

  task automatic program_dat(input int idx, input logic [6:0] addr, input logic dev);
    @(negedge clk_i);
    dat_wr_en_i   = 1'b1;
    dat_wr_idx_i  = idx[4:0];
    dat_wr_data_i = '{device: dev, rsvd: 1'b0, static_addr: addr};
    @(negedge clk_i);
    dat_wr_en_i   = 1'b0;
  endtask

  // Queue model updated mid-cycle, driven at the next falling edge
  task automatic push_cmd(input logic [63:0] w);
    @(posedge clk_i);
    cmd_mem[cmd_count[3:0]] = w;
    cmd_count++;
  endtask

  task automatic clear_traffic();
    fmt_q.delete();
    exp_fmt.delete();
    resp_q.delete();
    exp_resp.delete();
    cmd_ptr    = 0;
    cmd_count  = 0;
    pop_count  = 0;
    resp_count = 0;
  endtask

  task automatic wait_resps(input int n);
    int cyc;
    cyc = 0;
    while (resp_q.size() < n && cyc < 400) begin
      @(negedge clk_i);
      cyc++;
    end
    if (resp_q.size() < n) begin
      $display("Timeout at %0t: only %0d of %0d responses arrived", $time, resp_q.size(), n);
      errors++;
    end
  endtask

  task automatic wait_idle();
    int cyc;
    cyc = 0;
    @(negedge clk_i);
    while (!(i3c_fsm_idle_o && !resp_queue_wvalid_o) && cyc < 100) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!(i3c_fsm_idle_o && !resp_queue_wvalid_o)) begin
      $display("Timeout at %0t: block never returned to idle", $time);
      errors++;
    end
  endtask

  task automatic compare_traffic();
    assert (fmt_q.size() == exp_fmt.size()) else begin
      $display("Error at %0t: %0d format bytes, expected %0d", $time, fmt_q.size(),
               exp_fmt.size());
      errors++;
    end
    for (int i = 0; i < fmt_q.size() && i < exp_fmt.size(); i++) begin
      assert (fmt_q[i] === exp_fmt[i]) else begin
        $display("Error at %0t: byte %0d is %h, expected %h", $time, i, fmt_q[i], exp_fmt[i]);
        errors++;
      end
    end
    assert (resp_q.size() == exp_resp.size()) else begin
      $display("Error at %0t: %0d responses, expected %0d", $time, resp_q.size(),
               exp_resp.size());
      errors++;
    end
    for (int i = 0; i < resp_q.size() && i < exp_resp.size(); i++) begin
      assert (resp_q[i] === exp_resp[i]) else begin
        $display("Error at %0t: response %0d is %h, expected %h", $time, i, resp_q[i],
                 exp_resp[i]);
        errors++;
      end
    end
  endtask

  // One command end to end
  task automatic run_one(input logic [63:0] w, input logic [6:0] addr, input bit ok);
    clear_traffic();
    if (ok) expect_write(w, addr);
    else expect_reject(w);
    push_cmd(w);
    wait_resps(1);
    wait_idle();
    compare_traffic();
  endtask

  task automatic report(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_plain_write();
    int e;
    e = errors;
    program_dat(3, 7'h2A, 1'b1);
    for (int d = 1; d <= 4; d++) begin
      run_one(make_cmd(3'd1, 4'(d), 5'd3, 3'(d), 1'b0, d[0], 32'hD4C3_B2A1), 7'h2A, 1'b1);
    end
    report("plain immediate write", e);
  endtask

  task automatic test_def_byte();
    int e;
    e = errors;
    program_dat(9, 7'h51, 1'b1);
    for (int d = 5; d <= 7; d++) begin
      run_one(make_cmd(3'd1, 4'(d + 3), 5'd9, 3'(d), 1'b0, 1'b1, 32'h4433_2211), 7'h51, 1'b1);
    end
    report("defining byte forms", e);
  endtask

  task automatic test_backpressure();
    int e;
    e = errors;
    rand_ready = 1'b1;
    program_dat(17, 7'h0F, 1'b1);
    run_one(make_cmd(3'd1, 4'd2, 5'd17, 3'd4, 1'b0, 1'b1, 32'h5A6B_7C8D), 7'h0F, 1'b1);
    run_one(make_cmd(3'd1, 4'd6, 5'd17, 3'd7, 1'b0, 1'b0, 32'h0102_0304), 7'h0F, 1'b1);
    run_one(make_cmd(3'd1, 4'd9, 5'd17, 3'd2, 1'b0, 1'b1, 32'hFFEE_DDCC), 7'h0F, 1'b1);
    rand_ready = 1'b0;
    report("back-pressure", e);
  endtask

  task automatic test_unsupported();
    int e;
    e = errors;
    program_dat(4, 7'h33, 1'b1);
    program_dat(5, 7'h34, 1'b0);
    run_one(make_cmd(3'd0, 4'd11, 5'd4, 3'd2, 1'b0, 1'b1, 32'h1111_1111), 7'h33, 1'b0);
    run_one(make_cmd(3'd1, 4'd12, 5'd4, 3'd2, 1'b1, 1'b1, 32'h2222_2222), 7'h33, 1'b0);
    run_one(make_cmd(3'd1, 4'd13, 5'd5, 3'd2, 1'b0, 1'b1, 32'h3333_3333), 7'h34, 1'b0);
    report("unsupported commands", e);
  endtask

  task automatic test_back_to_back();
    int          e;
    logic [63:0] w [3];
    e = errors;
    program_dat(20, 7'h10, 1'b1);
    program_dat(21, 7'h21, 1'b1);
    program_dat(22, 7'h32, 1'b1);
    @(negedge clk_i);
    i3c_fsm_en_i = 1'b0;
    clear_traffic();
    w[0] = make_cmd(3'd1, 4'd1, 5'd20, 3'd1, 1'b0, 1'b1, 32'h0000_00A0);
    w[1] = make_cmd(3'd1, 4'd2, 5'd21, 3'd3, 1'b0, 1'b1, 32'h00B3_B2B1);
    w[2] = make_cmd(3'd1, 4'd3, 5'd22, 3'd6, 1'b0, 1'b0, 32'h0000_C2C1);
    expect_write(w[0], 7'h10);
    expect_write(w[1], 7'h21);
    expect_write(w[2], 7'h32);
    for (int i = 0; i < 3; i++) begin
      push_cmd(w[i]);
    end
    // Disabled window, nothing may pop
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
    end
    assert (pop_count == 0) else begin
      $display("Error at %0t: %0d pops while disabled", $time, pop_count);
      errors++;
    end
    i3c_fsm_en_i = 1'b1;
    wait_resps(3);
    wait_idle();
    compare_traffic();
    report("back-to-back with enable", e);
  endtask

  initial begin
    void'($urandom(32'h20e4_02db));
    rst_ni              = 1'b0;
    i3c_fsm_en_i        = 1'b0;
    cmd_queue_rvalid_i  = 1'b0;
    cmd_queue_rdata_i   = '0;
    fmt_fifo_rready_i   = 1'b1;
    resp_queue_wready_i = 1'b1;
    dat_wr_en_i         = 1'b0;
    dat_wr_idx_i        = '0;
    dat_wr_data_i       = '0;
    rand_ready          = 1'b0;
    errors              = 0;
    tests_run           = 0;
    tests_failed        = 0;
    clear_traffic();
    repeat (8) @(negedge clk_i);
    rst_ni       = 1'b1;
    @(negedge clk_i);
    // FSM reports idle out of reset
    assert (i3c_fsm_idle_o === 1'b1) else begin
      $display("Error at %0t: idle output low after reset", $time);
      errors++;
    end
    i3c_fsm_en_i = 1'b1;

    test_plain_write();
    test_def_byte();
    test_backpressure();
    test_unsupported();
    test_back_to_back();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
